//--- verilog/rv32_id_pkg.sv
`default_nettype none

package rv32_id_pkg;

  localparam int unsigned xlen     = 32;
  localparam int unsigned rf_idx_w = 5;
  localparam int unsigned rf_num   = 32;

  // major opcodes
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;

  // addi x0, x0, 0
  localparam logic [xlen-1:0] nop_insn = 32'h0000_0013;

  // ==========================================================================
  // ALU enable vector
  localparam int unsigned alu_en_w           = 9;
  localparam int unsigned alu_en_add         = 0;
  localparam int unsigned alu_en_cmp         = 1;
  localparam int unsigned alu_en_cmp_signed  = 2;
  localparam int unsigned alu_en_and         = 3;
  localparam int unsigned alu_en_or          = 4;
  localparam int unsigned alu_en_xor         = 5;
  localparam int unsigned alu_en_shift       = 6;
  localparam int unsigned alu_en_shift_left  = 7;
  localparam int unsigned alu_en_shift_arith = 8;

  // ==========================================================================
  // load/store kind vector, any bit on top
  localparam int unsigned mem_info_w = 9;
  localparam int unsigned mem_lb     = 0;
  localparam int unsigned mem_lh     = 1;
  localparam int unsigned mem_lw     = 2;
  localparam int unsigned mem_lbu    = 3;
  localparam int unsigned mem_lhu    = 4;
  localparam int unsigned mem_sb     = 5;
  localparam int unsigned mem_sh     = 6;
  localparam int unsigned mem_sw     = 7;
  localparam int unsigned mem_any    = 8;

  // one instruction word, six format views
  typedef union packed {
    struct packed {
      logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0; logic [4:0] rs1;
      logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3; logic [4:0] imm_4_0; logic [6:0] opcode;
    } s;
    struct packed {
      logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12; logic [4:0] rd; logic [6:0] opcode;
    } u;
    struct packed {
      logic imm_20; logic [9:0] imm_10_1; logic imm_11;
      logic [7:0] imm_19_12; logic [4:0] rd; logic [6:0] opcode;
    } j;
  } rv32_insn_u;

endpackage

`default_nettype wire

//--- verilog/id_dec_if.sv
`default_nettype none

interface id_dec_if
  import rv32_id_pkg::*;
();

  // second ALU operand when use_imm is set
  logic [xlen-1:0] imm;
  // offset for the jump target adder
  logic [xlen-1:0] tgt_imm;
  logic            use_imm;
  logic            op1_pc;
  // lui only
  logic            op1_zero;
  logic            is_sub;
  logic            is_branch;
  logic            is_jal;
  logic            is_jalr;
  logic [2:0]      br_funct3;

  modport decoder (
    output imm, tgt_imm, use_imm, op1_pc, op1_zero, is_sub,
    output is_branch, is_jal, is_jalr, br_funct3
  );

  modport consumer (
    input imm, tgt_imm, use_imm, op1_pc, op1_zero, is_sub,
    input is_branch, is_jal, is_jalr, br_funct3
  );

endinterface

`default_nettype wire

//--- verilog/id_issue_sel.sv
`default_nettype none

module id_issue_sel
  import rv32_id_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n,
  input  logic [xlen-1:0] insn_fetch,
  input  logic            i_hready,
  input  logic            d_hready,
  input  logic            div_busy,
  input  logic            itcm_stall,
  output rv32_insn_u      insn,
  output logic            hold
);

  // last issued word, replayed while held
  rv32_insn_u insn_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      insn_q <= nop_insn;
    end else begin
      insn_q <= insn;
    end
  end

  // data side waiting or divider busy
  assign hold = div_busy | ~d_hready;

  always_comb begin
    if (hold) begin
      insn = insn_q;
    end else if (!i_hready || itcm_stall) begin
      // bubble, fetch word is dropped
      insn = nop_insn;
    end else begin
      insn = insn_fetch;
    end
  end

endmodule

`default_nettype wire

//--- verilog/id_decoder.sv
`default_nettype none

module id_decoder
  import rv32_id_pkg::*;
(
  input  rv32_insn_u            insn,
  input  logic                  hold,
  input  logic [rf_num-1:0]     stop_flag,
  output logic [rf_idx_w-1:0]   rs1_idx,
  output logic [rf_idx_w-1:0]   rs2_idx,
  output logic [rf_idx_w-1:0]   rd_idx,
  output logic                  reg_write,
  output logic                  reg_write_all,
  output logic                  mem_read,
  output logic                  mem_write,
  output logic                  raw_stall,
  output logic [mem_info_w-1:0] mem_info,
  output logic [alu_en_w-1:0]   alu_op_en,
  id_dec_if.decoder             dec
);

  logic [7:0]      f3_dec;
  logic            f7_zero;
  logic            f7_alt;
  logic            is_load, is_store, is_branch, is_jal, is_jalr;
  logic            is_opimm, is_op, is_lui, is_auipc;
  logic            r_std;
  logic            sh_std;
  logic            sh_alt;
  logic            rs1_need;
  logic            rs2_need;
  logic [xlen-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;

  assign rs1_idx = insn.r.rs1;
  assign rs2_idx = insn.r.rs2;
  assign rd_idx  = insn.r.rd;

  // ==========================================================================
  // opcode and function fields
  assign f3_dec  = 8'b1 << insn.r.funct3;
  assign f7_zero = (insn.r.funct7 == 7'b0000000);
  assign f7_alt  = (insn.r.funct7 == 7'b0100000);

  assign is_load   = (insn.r.opcode == op_load);
  assign is_store  = (insn.r.opcode == op_store);
  assign is_branch = (insn.r.opcode == op_branch);
  assign is_jal    = (insn.r.opcode == op_jal);
  assign is_jalr   = (insn.r.opcode == op_jalr);
  assign is_opimm  = (insn.r.opcode == op_imm);
  assign is_op     = (insn.r.opcode == op_reg);
  assign is_lui    = (insn.r.opcode == op_lui);
  assign is_auipc  = (insn.r.opcode == op_auipc);

  // plain register ops, and shifts with their funct7 check
  assign r_std  = (is_op & f7_zero) | is_opimm;
  assign sh_std = (is_op | is_opimm) & f7_zero;
  assign sh_alt = (is_op | is_opimm) & f7_alt;

  // ==========================================================================
  // immediates
  assign i_imm = {{20{insn.i.imm_11_0[11]}}, insn.i.imm_11_0};
  assign s_imm = {{20{insn.s.imm_11_5[6]}}, insn.s.imm_11_5, insn.s.imm_4_0};
  assign b_imm = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                  insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
  assign u_imm = {insn.u.imm_31_12, 12'b0};
  assign j_imm = {{11{insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
                  insn.j.imm_11, insn.j.imm_10_1, 1'b0};

  always_comb begin
    dec.imm = '0;
    if (is_opimm || is_load) begin
      dec.imm = i_imm;
    end else if (is_store) begin
      dec.imm = s_imm;
    end else if (is_lui || is_auipc) begin
      dec.imm = u_imm;
    end else if (is_jal || is_jalr) begin
      // link value is pc + 4
      dec.imm = 32'd4;
    end
  end

  assign dec.tgt_imm = ({xlen{is_branch}} & b_imm)
                     | ({xlen{is_jal}}    & j_imm)
                     | ({xlen{is_jalr}}   & i_imm);

  assign dec.use_imm   = is_opimm | is_load | is_store | is_lui | is_auipc
                       | is_jal | is_jalr;
  assign dec.op1_pc    = is_auipc | is_jal | is_jalr;
  assign dec.op1_zero  = is_lui;
  assign dec.is_sub    = is_op & f3_dec[0] & f7_alt;
  assign dec.is_branch = is_branch;
  assign dec.is_jal    = is_jal;
  assign dec.is_jalr   = is_jalr;
  assign dec.br_funct3 = insn.b.funct3;

  // ==========================================================================
  // load/store kind and ALU groups
  always_comb begin
    mem_info          = '0;
    mem_info[mem_lb]  = is_load & f3_dec[0];
    mem_info[mem_lh]  = is_load & f3_dec[1];
    mem_info[mem_lw]  = is_load & f3_dec[2];
    mem_info[mem_lbu] = is_load & f3_dec[4];
    mem_info[mem_lhu] = is_load & f3_dec[5];
    mem_info[mem_sb]  = is_store & f3_dec[0];
    mem_info[mem_sh]  = is_store & f3_dec[1];
    mem_info[mem_sw]  = is_store & f3_dec[2];
    mem_info[mem_any] = |mem_info[mem_sw:mem_lb];
  end

  always_comb begin
    alu_op_en = '0;
    // add, sub, addi, auipc, address and link adds
    alu_op_en[alu_en_add] = (is_opimm & f3_dec[0]) | (is_op & f3_dec[0] & (f7_zero | f7_alt))
                          | is_auipc | mem_info[mem_any] | is_jal | is_jalr;
    alu_op_en[alu_en_cmp]         = r_std & (f3_dec[2] | f3_dec[3]);
    alu_op_en[alu_en_cmp_signed]  = r_std & f3_dec[2];
    alu_op_en[alu_en_and]         = r_std & f3_dec[7];
    alu_op_en[alu_en_or]          = (r_std & f3_dec[6]) | is_lui;
    alu_op_en[alu_en_xor]         = r_std & f3_dec[4];
    alu_op_en[alu_en_shift]       = sh_std & (f3_dec[1] | f3_dec[5]);
    alu_op_en[alu_en_shift_left]  = sh_std & f3_dec[1];
    alu_op_en[alu_en_shift_arith] = sh_alt & f3_dec[5];
  end

  // write-back, loads return later through the LSU
  assign reg_write_all = is_op | is_opimm | is_lui | is_auipc | is_jal | is_jalr | is_load;
  assign reg_write     = reg_write_all & ~is_load;
  assign mem_read      = is_load;
  assign mem_write     = is_store;

  // RAW check, masked while the same word is replayed
  assign rs1_need  = is_branch | is_store | is_op | is_opimm | is_load | is_jalr;
  assign rs2_need  = is_branch | is_store | is_op;
  assign raw_stall = ((rs1_need & stop_flag[rs1_idx]) | (rs2_need & stop_flag[rs2_idx]))
                   & ~hold;

endmodule

`default_nettype wire

//--- verilog/id_branch.sv
`default_nettype none

module id_branch
  import rv32_id_pkg::*;
(
  id_dec_if.consumer      dec,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  output logic            take_jump,
  output logic [xlen-1:0] tgt_op1,
  output logic [xlen-1:0] tgt_op2
);

  logic br_eq;
  logic br_lt;
  logic br_ltu;
  logic br_cond;

  assign br_eq  = (rs1_data == rs2_data);
  assign br_lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign br_ltu = (rs1_data < rs2_data);

  always_comb begin
    case (dec.br_funct3)
      3'b000:  br_cond = br_eq;
      3'b001:  br_cond = ~br_eq;
      3'b100:  br_cond = br_lt;
      3'b101:  br_cond = ~br_lt;
      3'b110:  br_cond = br_ltu;
      3'b111:  br_cond = ~br_ltu;
      // 010 and 011 are not branches
      default: br_cond = 1'b0;
    endcase
  end

  assign take_jump = dec.is_jal | dec.is_jalr | (dec.is_branch & br_cond);

  // jalr adds to rs1, everything else is pc relative
  assign tgt_op1 = (dec.is_jal | dec.is_branch) ? pc : rs1_data;
  assign tgt_op2 = dec.tgt_imm;

endmodule

`default_nettype wire

//--- verilog/id_operand_sel.sv
`default_nettype none

module id_operand_sel
  import rv32_id_pkg::*;
(
  id_dec_if.consumer      dec,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  output logic [xlen-1:0] op1,
  output logic [xlen-1:0] op2,
  output logic            add_cin
);

  // ==========================================================================
  // first operand
  always_comb begin
    if (dec.op1_zero) begin
      op1 = '0;
    end else if (dec.op1_pc) begin
      // auipc and link address
      op1 = pc;
    end else begin
      op1 = rs1_data;
    end
  end

  // ==========================================================================
  // second operand
  always_comb begin
    if (dec.is_sub) begin
      // a - b as a + ~b + 1
      op2 = ~rs2_data;
    end else if (dec.use_imm) begin
      op2 = dec.imm;
    end else begin
      op2 = rs2_data;
    end
  end

  assign add_cin = dec.is_sub;

endmodule

`default_nettype wire

//--- verilog/id_stage.sv
`default_nettype none

module id_stage
  import rv32_id_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [xlen-1:0]       insn_fetch,
  input  logic                  i_hready,
  input  logic                  d_hready,
  input  logic                  div_busy,
  input  logic                  itcm_stall,
  input  logic [rf_num-1:0]     stop_flag,
  input  logic [xlen-1:0]       pc,
  input  logic [xlen-1:0]       rs1_data,
  input  logic [xlen-1:0]       rs2_data,
  output logic [xlen-1:0]       insn,
  output logic [rf_idx_w-1:0]   rs1_idx,
  output logic [rf_idx_w-1:0]   rs2_idx,
  output logic [rf_idx_w-1:0]   rd_idx,
  output logic                  reg_write,
  output logic                  reg_write_all,
  output logic                  mem_read,
  output logic                  mem_write,
  output logic [mem_info_w-1:0] mem_info,
  output logic [alu_en_w-1:0]   alu_op_en,
  output logic                  raw_stall,
  output logic                  take_jump,
  output logic [xlen-1:0]       tgt_op1,
  output logic [xlen-1:0]       tgt_op2,
  output logic [xlen-1:0]       op1,
  output logic [xlen-1:0]       op2,
  output logic                  add_cin
);

  rv32_insn_u issued;
  logic       hold;

  id_dec_if dec_if ();

  assign insn = issued;

  id_issue_sel u_issue_sel (
    .clk        (clk),
    .arst_n     (arst_n),
    .insn_fetch (insn_fetch),
    .i_hready   (i_hready),
    .d_hready   (d_hready),
    .div_busy   (div_busy),
    .itcm_stall (itcm_stall),
    .insn       (issued),
    .hold       (hold)
  );

  id_decoder u_decoder (
    .insn          (issued),
    .hold          (hold),
    .stop_flag     (stop_flag),
    .rs1_idx       (rs1_idx),
    .rs2_idx       (rs2_idx),
    .rd_idx        (rd_idx),
    .reg_write     (reg_write),
    .reg_write_all (reg_write_all),
    .mem_read      (mem_read),
    .mem_write     (mem_write),
    .raw_stall     (raw_stall),
    .mem_info      (mem_info),
    .alu_op_en     (alu_op_en),
    .dec           (dec_if.decoder)
  );

  id_branch u_branch (
    .dec       (dec_if.consumer),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .take_jump (take_jump),
    .tgt_op1   (tgt_op1),
    .tgt_op2   (tgt_op2)
  );

  id_operand_sel u_operand_sel (
    .dec      (dec_if.consumer),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .op1      (op1),
    .op2      (op2),
    .add_cin  (add_cin)
  );

endmodule

`default_nettype wire

//--- verif/id_stage_tb.sv
`default_nettype none

module id_stage_tb
  import rv32_id_pkg::*;
();

  localparam logic [31:0] pc_val  = 32'h0000_1000;
  localparam logic [31:0] d1      = 32'h0000_0064;
  localparam logic [31:0] d2      = 32'h0000_0019;
  localparam logic [31:0] neg     = 32'hffff_fff0;
  localparam logic [31:0] all_set = 32'hffff_ffff;
  // addi x3,x1,5 / add x3,x1,x2 / sub x3,x1,x2 / lui x3,0x12345 / auipc x3,1
  localparam logic [31:0] addi_w  = 32'h0050_8193;
  localparam logic [31:0] add_w   = 32'h0020_81b3;
  localparam logic [31:0] sub_w   = 32'h4020_81b3;
  localparam logic [31:0] lui_w   = 32'h1234_51b7;
  localparam logic [31:0] auipc_w = 32'h0000_1197;
  // lw x3,8(x1) / sb x2,4(x1) / jal x1,2048 / jalr x1,12(x5)
  localparam logic [31:0] lw_w    = 32'h0080_a183;
  localparam logic [31:0] sb_w    = 32'h0020_8223;
  localparam logic [31:0] jal_w   = 32'h0010_00ef;
  localparam logic [31:0] jalr_w  = 32'h00c2_80e7;
  // beq x1,x2,16, other branches differ in funct3 only
  localparam logic [31:0] beq_w   = 32'h0020_8863;

  // ctl is {reg_write, reg_write_all, mem_read, mem_write, raw_stall, take_jump, add_cin}
  // idx is the raw {rs1, rs2, rd} fields of the issued word
  typedef struct packed {
    logic [31:0] fetch;
    logic [3:0]  strb;
    logic [31:0] stop;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic        rnd;
    logic [31:0] e_insn;
    logic [6:0]  e_ctl;
    logic [8:0]  e_mem;
    logic [8:0]  e_alu;
    logic [31:0] e_tgt1;
    logic [31:0] e_tgt2;
    logic [31:0] e_op1;
    logic [31:0] e_op2;
    logic [14:0] e_idx;
  } row_t;

  logic        clk, arst_n, i_hready, d_hready, div_busy, itcm_stall;
  logic [31:0] insn_fetch, stop_flag, pc, rs1_data, rs2_data;
  logic [31:0] insn, tgt_op1, tgt_op2, op1, op2;
  logic [4:0]  rs1_idx, rs2_idx, rd_idx;
  logic        reg_write, reg_write_all, mem_read, mem_write, raw_stall, take_jump, add_cin;
  logic [8:0]  mem_info, alu_op_en;

  row_t        rows[$];
  int          cycles = 0;
  int          cycle_limit, entry_errs, pass_cnt, fail_cnt;

  id_stage dut (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic add_row(input logic [31:0] fetch, input logic [3:0] strb,
                         input logic [31:0] stop, rs1, rs2, input logic rnd,
                         input logic [31:0] e_insn, input logic [6:0] e_ctl,
                         input logic [8:0] e_mem, e_alu,
                         input logic [31:0] e_tgt1, e_tgt2, e_op1, e_op2,
                         input logic [14:0] e_idx);
    rows.push_back({fetch, strb, stop, rs1, rs2, rnd, e_insn, e_ctl, e_mem, e_alu,
                    e_tgt1, e_tgt2, e_op1, e_op2, e_idx});
  endtask

  // branches read x1 and x2 and target pc + 16
  task automatic add_branch(input logic [2:0] f3, input logic [31:0] a, b,
                            input logic taken);
    add_row(beq_w | (f3 << 12), 4'b1100, 32'h0, a, b, 1'b0, beq_w | (f3 << 12),
            {5'b0, taken, 1'b0}, 9'h000, 9'h000, pc_val, 32'd16, a, b,
            {5'd1, 5'd2, 5'd16});
  endtask

  task automatic check_word(input string name, input logic [31:0] got, exp);
    assert (got === exp) else begin
      $display("error %0t: %s is %h, expected %h", $time, name, got, exp);
      entry_errs++;
    end
  endtask

  initial begin
    row_t r;
    clk = 1'b0;
    arst_n = 1'b0;
    {i_hready, d_hready, div_busy, itcm_stall} = 4'b0000;
    insn_fetch = '0;
    stop_flag = '0;
    pc = '0;
    rs1_data = '0;
    rs2_data = '0;
    void'($urandom(32'h8cddffdf));

    // ========================================================================
    // strb is {i_hready, d_hready, div_busy, itcm_stall}
    add_row(add_w, 4'b1000, all_set, d1, d2, 0, nop_insn, 7'b1100000, 9'h000, 9'h001,
            d1, 32'h0, d1, 32'h0, {5'd0, 5'd0, 5'd0});
    add_row(addi_w, 4'b1100, 32'h20, d1, d2, 0, addi_w, 7'b1100000, 9'h000, 9'h001,
            d1, 32'h0, d1, 32'd5, {5'd1, 5'd5, 5'd3});
    add_row(add_w, 4'b1100, 32'h0, d1, d2, 0, add_w, 7'b1100000, 9'h000, 9'h001,
            d1, 32'h0, d1, d2, {5'd1, 5'd2, 5'd3});
    add_row(add_w, 4'b1100, 32'h4, d1, d2, 0, add_w, 7'b1100100, 9'h000, 9'h001,
            d1, 32'h0, d1, d2, {5'd1, 5'd2, 5'd3});
    add_row(sub_w, 4'b1000, 32'h4, d1, d2, 0, add_w, 7'b1100000, 9'h000, 9'h001,
            d1, 32'h0, d1, d2, {5'd1, 5'd2, 5'd3});
    add_row(sub_w, 4'b1100, 32'h0, d1, d2, 0, sub_w, 7'b1100001, 9'h000, 9'h001,
            d1, 32'h0, d1, ~d2, {5'd1, 5'd2, 5'd3});
    add_row(lui_w, 4'b1110, 32'h0, d1, d2, 0, sub_w, 7'b1100001, 9'h000, 9'h001,
            d1, 32'h0, d1, ~d2, {5'd1, 5'd2, 5'd3});
    add_row(lui_w, 4'b1100, all_set, d1, d2, 0, lui_w, 7'b1100000, 9'h000, 9'h010,
            d1, 32'h0, 32'h0, 32'h1234_5000, {5'd8, 5'd3, 5'd3});
    add_row(auipc_w, 4'b1100, 32'h0, d1, d2, 0, auipc_w, 7'b1100000, 9'h000, 9'h001,
            d1, 32'h0, pc_val, 32'h0000_1000, {5'd0, 5'd0, 5'd3});
    add_row(lw_w, 4'b1100, 32'h2, d1, d2, 0, lw_w, 7'b0110100, 9'h104, 9'h001,
            d1, 32'h0, d1, 32'd8, {5'd1, 5'd8, 5'd3});
    add_row(sb_w, 4'b1100, 32'h0, d1, d2, 0, sb_w, 7'b0001000, 9'h120, 9'h001,
            d1, 32'h0, d1, 32'd4, {5'd1, 5'd2, 5'd4});
    add_row(add_w, 4'b0100, 32'h0, d1, d2, 0, nop_insn, 7'b1100000, 9'h000, 9'h001,
            d1, 32'h0, d1, 32'h0, {5'd0, 5'd0, 5'd0});
    add_row(add_w, 4'b1101, 32'h0, d1, d2, 0, nop_insn, 7'b1100000, 9'h000, 9'h001,
            d1, 32'h0, d1, 32'h0, {5'd0, 5'd0, 5'd0});
    add_branch(3'b000, 32'd5, 32'd5, 1'b1);
    add_branch(3'b000, 32'd5, 32'd6, 1'b0);
    add_branch(3'b001, 32'd5, 32'd6, 1'b1);
    add_branch(3'b001, 32'd5, 32'd5, 1'b0);
    add_branch(3'b100, neg, 32'd1, 1'b1);
    add_branch(3'b100, 32'd1, neg, 1'b0);
    add_branch(3'b101, 32'd1, neg, 1'b1);
    add_branch(3'b101, neg, 32'd1, 1'b0);
    add_branch(3'b110, 32'd1, neg, 1'b1);
    add_branch(3'b110, neg, 32'd1, 1'b0);
    add_branch(3'b111, neg, 32'd1, 1'b1);
    add_branch(3'b111, 32'd1, neg, 1'b0);
    add_row(jal_w, 4'b1100, 32'h0, d1, d2, 1, jal_w, 7'b1100010, 9'h000, 9'h001,
            pc_val, 32'h800, pc_val, 32'd4, {5'd0, 5'd1, 5'd1});
    add_row(jalr_w, 4'b1100, 32'h0, d1, d2, 0, jalr_w, 7'b1100010, 9'h000, 9'h001,
            d1, 32'd12, pc_val, 32'd4, {5'd5, 5'd12, 5'd1});
    cycle_limit = 16 + 2 * rows.size() + 20;

    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      // register data does not reach any checked output
      if (r.rnd) begin
        r.rs1 = $urandom;
        r.rs2 = $urandom;
      end
      @(posedge clk);
      insn_fetch <= r.fetch;
      {i_hready, d_hready, div_busy, itcm_stall} <= r.strb;
      stop_flag <= r.stop;
      pc <= pc_val;
      rs1_data <= r.rs1;
      rs2_data <= r.rs2;
      @(negedge clk);
      entry_errs = 0;
      check_word("insn", insn, r.e_insn);
      check_word("controls", {reg_write, reg_write_all, mem_read, mem_write, raw_stall,
                 take_jump, add_cin}, r.e_ctl);
      check_word("reg indices", {rs1_idx, rs2_idx, rd_idx}, r.e_idx);
      check_word("mem_info", mem_info, r.e_mem);
      check_word("alu_op_en", alu_op_en, r.e_alu);
      check_word("tgt_op1", tgt_op1, r.e_tgt1);
      check_word("tgt_op2", tgt_op2, r.e_tgt2);
      check_word("op1", op1, r.e_op1);
      check_word("op2", op2, r.e_op2);
      if (entry_errs == 0) pass_cnt++;
      else fail_cnt++;
      $display("entry %0d %s", i, (entry_errs == 0) ? "passed" : "failed");
    end

    $display("%0d entries passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- id_stage.f
verilog/rv32_id_pkg.sv
verilog/id_dec_if.sv
verilog/id_issue_sel.sv
verilog/id_decoder.sv
verilog/id_branch.sv
verilog/id_operand_sel.sv
verilog/id_stage.sv
verif/id_stage_tb.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - verilog/rv32_id_pkg.sv
  - verilog/id_dec_if.sv
  - verilog/id_issue_sel.sv
  - verilog/id_decoder.sv
  - verilog/id_branch.sv
  - verilog/id_operand_sel.sv
  - verilog/id_stage.sv
  - target: test
    files:
      - verif/id_stage_tb.sv
